//--- src/simd_pkg.sv
// SIMD package with operation and width codes, lane word views and unit latencies
package simd_pkg;

    localparam int ELEN  = 64;  // Lane width
    localparam int TAG_W = 5;

    localparam int LAT_ALU = 1;
    localparam int LAT_MUL = 2;
    localparam int LAT_RED = 3;
    localparam int MAX_LAT = LAT_RED;  // Reductions are the slowest

    typedef enum logic [3:0] {
        VNOP, VADD, VSUB, VAND, VOR, VXOR,
        VMSEQ, VMSLT, VMSLTU, VMUL, VMV_X_S,
        VREDSUM, VREDAND, VREDOR, VREDXOR
    } simd_op_e;

    typedef enum logic [1:0] {
        SEW_8, SEW_16, SEW_32, SEW_64
    } sew_e;

    // One lane word seen as elements of each width
    typedef union packed {
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
        logic [63:0]      d;
    } lane_word_u;

    function automatic int unsigned sew_elems_per_lane(sew_e sew);
        case (sew)
            SEW_8:   return 8;
            SEW_16:  return 4;
            SEW_32:  return 2;
            default: return 1;
        endcase
    endfunction

    function automatic int unsigned op_latency(simd_op_e op);
        case (op)
            VMUL:                               return LAT_MUL;
            VREDSUM, VREDAND, VREDOR, VREDXOR:  return LAT_RED;
            default:                            return LAT_ALU;
        endcase
    endfunction

    // Element idx of a lane word, sign-extended to 64 bits
    function automatic logic [63:0] elem_get(lane_word_u word, sew_e sew, logic [2:0] idx);
        case (sew)
            SEW_8:   return 64'($signed(word.b[idx]));
            SEW_16:  return 64'($signed(word.h[idx[1:0]]));
            SEW_32:  return 64'($signed(word.w[idx[0]]));
            default: return word.d;
        endcase
    endfunction

    // Writes the low SEW bits of val into element idx
    function automatic lane_word_u elem_put(lane_word_u word, sew_e sew, logic [2:0] idx,
                                            logic [63:0] val);
        elem_put = word;
        case (sew)
            SEW_8:   elem_put.b[idx]      = val[7:0];
            SEW_16:  elem_put.h[idx[1:0]] = val[15:0];
            SEW_32:  elem_put.w[idx[0]]   = val[31:0];
            default: elem_put.d           = val;
        endcase
    endfunction

endpackage

//--- src/simd_instr_if.sv
// Instruction bus carrying one vector instruction with all of its operands
`timescale 1ns/1ns

interface simd_instr_if #(
    parameter int VLEN = 128
);
    import simd_pkg::*;

    logic             valid;
    simd_op_e         op;
    sew_e             sew;
    logic             scalar_src;  // rs1 replaces vs1
    logic             use_mask;
    logic [VLEN-1:0]  vs1;
    logic [VLEN-1:0]  vs2;
    logic [VLEN-1:0]  old_vd;
    logic [VLEN-1:0]  vm;
    logic [ELEN-1:0]  rs1;
    logic [TAG_W-1:0] tag;

    modport src (output valid, op, sew, scalar_src, use_mask, vs1, vs2, old_vd, vm, rs1, tag);
    modport dst (input valid, op, sew, scalar_src, use_mask, vs1, vs2, old_vd, vm, rs1, tag);

endinterface

//--- src/simd_operand_mux.sv
// Operand mux that broadcasts rs1 per element width and picks the first source vector
`timescale 1ns/1ns

module simd_operand_mux #(
    parameter int VLEN = 128
) (
    simd_instr_if.dst       issue_bus,
    output logic [VLEN-1:0] vs1_sel_o
);
    import simd_pkg::*;

    lane_word_u rs1_rep;

    always_comb begin
        case (issue_bus.sew)
            SEW_8:   rs1_rep.b = {8{issue_bus.rs1[7:0]}};
            SEW_16:  rs1_rep.h = {4{issue_bus.rs1[15:0]}};
            SEW_32:  rs1_rep.w = {2{issue_bus.rs1[31:0]}};
            default: rs1_rep.d = issue_bus.rs1;
        endcase
    end

    // Same lane pattern repeats across the whole vector
    assign vs1_sel_o = issue_bus.scalar_src ? {(VLEN / ELEN){rs1_rep.d}} : issue_bus.vs1;

endmodule

//--- src/simd_lane.sv
// Vector lane with element-wise ALU, compares and a two-stage low-half multiply
`timescale 1ns/1ns

module simd_lane (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  simd_pkg::simd_op_e   op_i,
    input  simd_pkg::sew_e       sew_i,
    input  simd_pkg::lane_word_u a_i,    // Source one, vector or broadcast scalar
    input  simd_pkg::lane_word_u b_i,    // Source two
    output simd_pkg::lane_word_u alu_o,
    output logic [7:0]           cmp_o,  // Bit i belongs to element i
    output simd_pkg::lane_word_u mul_o
);
    import simd_pkg::*;

    lane_word_u  alu_d;
    logic [7:0]  cmp_d;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] res;

    // Multiply stage one
    simd_op_e    m1_op;
    sew_e        m1_sew;
    lane_word_u  m1_a;
    lane_word_u  m1_b;
    lane_word_u  mul_d;

    // Elements are sign-extended, so low bits and both compare orders stay exact
    always_comb begin
        alu_d = '0;
        cmp_d = '0;
        ea    = '0;
        eb    = '0;
        res   = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < sew_elems_per_lane(sew_i)) begin
                ea = elem_get(a_i, sew_i, 3'(i));
                eb = elem_get(b_i, sew_i, 3'(i));
                case (op_i)
                    VADD:    res = eb + ea;
                    VSUB:    res = eb - ea;  // vs2 minus vs1
                    VAND:    res = eb & ea;
                    VOR:     res = eb | ea;
                    VXOR:    res = eb ^ ea;
                    default: res = '0;
                endcase
                alu_d = elem_put(alu_d, sew_i, 3'(i), res);
                case (op_i)
                    VMSEQ:   cmp_d[i] = (eb == ea);
                    VMSLT:   cmp_d[i] = ($signed(eb) < $signed(ea));
                    VMSLTU:  cmp_d[i] = (eb < ea);
                    default: cmp_d[i] = 1'b0;
                endcase
            end
        end
    end

    always_comb begin
        mul_d = '0;
        for (int i = 0; i < 8; i++) begin
            if ((m1_op == VMUL) && (i < sew_elems_per_lane(m1_sew))) begin
                mul_d = elem_put(mul_d, m1_sew, 3'(i),
                                 elem_get(m1_a, m1_sew, 3'(i)) * elem_get(m1_b, m1_sew, 3'(i)));
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            alu_o  <= '0;
            cmp_o  <= '0;
            m1_op  <= VNOP;
            m1_sew <= SEW_8;
            m1_a   <= '0;
            m1_b   <= '0;
            mul_o  <= '0;
        end else begin
            alu_o  <= alu_d;
            cmp_o  <= cmp_d;
            m1_op  <= op_i;
            m1_sew <= sew_i;
            m1_a   <= a_i;
            m1_b   <= b_i;
            mul_o  <= mul_d;
        end
    end

endmodule

//--- src/simd_latency_pipe.sv
// Latency pipe that delays each instruction by its unit latency and presents completions
`timescale 1ns/1ns

module simd_latency_pipe #(
    parameter int VLEN = 128
) (
    input  logic      clk_i,
    input  logic      rstn_i,
    simd_instr_if.dst issue_bus,
    simd_instr_if.src done_bus
);
    import simd_pkg::*;

    typedef struct packed {
        logic             valid;
        simd_op_e         op;
        sew_e             sew;
        logic             scalar_src;
        logic             use_mask;
        logic [VLEN-1:0]  vs1;
        logic [VLEN-1:0]  vs2;
        logic [VLEN-1:0]  old_vd;
        logic [VLEN-1:0]  vm;
        logic [ELEN-1:0]  rs1;
        logic [TAG_W-1:0] tag;
    } instr_t;

    instr_t issue_d;
    instr_t head [1:MAX_LAT];
    instr_t done_d;

    assign issue_d = '{valid: issue_bus.valid, op: issue_bus.op, sew: issue_bus.sew,
                       scalar_src: issue_bus.scalar_src, use_mask: issue_bus.use_mask,
                       vs1: issue_bus.vs1, vs2: issue_bus.vs2, old_vd: issue_bus.old_vd,
                       vm: issue_bus.vm, rs1: issue_bus.rs1, tag: issue_bus.tag};

    // One shift chain per latency, l slots deep
    for (genvar l = 1; l <= MAX_LAT; l++) begin : g_chain
        instr_t chain_q [l];
        logic   take;

        assign take = issue_bus.valid && (op_latency(issue_bus.op) == l);

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                for (int j = 0; j < l; j++) begin
                    chain_q[j] <= '0;
                end
            end else begin
                chain_q[0] <= take ? issue_d : '0;
                for (int j = 1; j < l; j++) begin
                    chain_q[j] <= chain_q[j-1];
                end
            end
        end

        assign head[l] = chain_q[l-1];
    end

    always_comb begin
        done_d = '0;
        for (int l = 1; l <= MAX_LAT; l++) begin
            if (head[l].valid) begin
                done_d = head[l];  // Longest latency wins a collision
            end
        end
    end

    assign done_bus.valid      = done_d.valid;
    assign done_bus.op         = done_d.op;
    assign done_bus.sew        = done_d.sew;
    assign done_bus.scalar_src = done_d.scalar_src;
    assign done_bus.use_mask   = done_d.use_mask;
    assign done_bus.vs1        = done_d.vs1;
    assign done_bus.vs2        = done_d.vs2;
    assign done_bus.old_vd     = done_d.old_vd;
    assign done_bus.vm         = done_d.vm;
    assign done_bus.rs1        = done_d.rs1;
    assign done_bus.tag        = done_d.tag;

endmodule

//--- src/simd_reduction.sv
// Reduction unit folding all vs2 elements into element 0 of vs1 over three stages
`timescale 1ns/1ns

module simd_reduction #(
    parameter int  VLEN  = 128,
    localparam int LANES = VLEN / simd_pkg::ELEN
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  simd_pkg::simd_op_e op_i,
    input  simd_pkg::sew_e     sew_i,
    input  logic [VLEN-1:0]    vs1_i,
    input  logic [VLEN-1:0]    vs2_i,
    output logic [63:0]        red_o
);
    import simd_pkg::*;

    function automatic logic [63:0] red_fn(simd_op_e op, logic [63:0] x, logic [63:0] y);
        case (op)
            VREDAND: return x & y;
            VREDOR:  return x | y;
            VREDXOR: return x ^ y;
            default: return x + y;
        endcase
    endfunction

    simd_op_e               s1_op;
    sew_e                   s1_sew;
    lane_word_u             s1_seed;  // Lane 0 of vs1
    lane_word_u [LANES-1:0] s1_vs2;

    simd_op_e               s2_op;
    sew_e                   s2_sew;
    logic [63:0]            s2_seed;
    logic [LANES-1:0][63:0] s2_part;

    logic [LANES-1:0][63:0] part_d;
    logic [63:0]            total_d;

    // Per-lane fold
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            part_d[l] = elem_get(s1_vs2[l], s1_sew, 3'd0);
            for (int i = 1; i < 8; i++) begin
                if (i < sew_elems_per_lane(s1_sew)) begin
                    part_d[l] = red_fn(s1_op, part_d[l], elem_get(s1_vs2[l], s1_sew, 3'(i)));
                end
            end
        end
    end

    always_comb begin
        total_d = s2_seed;
        for (int l = 0; l < LANES; l++) begin
            total_d = red_fn(s2_op, total_d, s2_part[l]);
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_op   <= VNOP;
            s1_sew  <= SEW_8;
            s1_seed <= '0;
            s1_vs2  <= '0;
            s2_op   <= VNOP;
            s2_sew  <= SEW_8;
            s2_seed <= '0;
            s2_part <= '0;
            red_o   <= '0;
        end else begin
            s1_op   <= op_i;
            s1_sew  <= sew_i;
            s1_seed <= vs1_i[63:0];
            s1_vs2  <= vs2_i;
            s2_op   <= s1_op;
            s2_sew  <= s1_sew;
            s2_seed <= elem_get(s1_seed, s1_sew, 3'd0);
            s2_part <= part_d;
            red_o   <= elem_put('0, s2_sew, 3'd0, total_d);  // Upper bits cleared
        end
    end

endmodule

//--- src/simd_result_merge.sv
// Result merge that picks the unit result, applies the mask and drives both writebacks
`timescale 1ns/1ns

module simd_result_merge #(
    parameter int  VLEN  = 128,
    localparam int LANES = VLEN / simd_pkg::ELEN
) (
    simd_instr_if.dst                        done_bus,
    input  simd_pkg::lane_word_u [LANES-1:0] alu_i,
    input  simd_pkg::lane_word_u [LANES-1:0] mul_i,
    input  logic [LANES-1:0][7:0]            cmp_i,
    input  logic [63:0]                      red_i,
    output logic                             vec_valid_o,
    output logic [simd_pkg::TAG_W-1:0]       vec_tag_o,
    output logic [VLEN-1:0]                  vec_result_o,
    output logic                             scalar_valid_o,
    output logic [simd_pkg::TAG_W-1:0]       scalar_tag_o,
    output logic [63:0]                      scalar_result_o
);
    import simd_pkg::*;

    lane_word_u [LANES-1:0] old_w;
    lane_word_u [LANES-1:0] elem_w;
    lane_word_u             vs2_l0;
    logic [VLEN-1:0]        mask_res;
    int unsigned            epl;  // Elements per lane
    logic                   is_cmp;
    logic                   is_red;
    logic                   is_mv;
    logic                   apply_mask;

    assign old_w      = done_bus.old_vd;
    assign vs2_l0     = done_bus.vs2[63:0];
    assign epl        = sew_elems_per_lane(done_bus.sew);
    assign is_cmp     = done_bus.op inside {VMSEQ, VMSLT, VMSLTU};
    assign is_red     = done_bus.op inside {VREDSUM, VREDAND, VREDOR, VREDXOR};
    assign is_mv      = (done_bus.op == VMV_X_S);
    assign apply_mask = done_bus.use_mask && !is_red;

    // Element results, inactive elements keep old_vd
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            elem_w[l] = (done_bus.op == VMUL) ? mul_i[l] : alu_i[l];
            for (int i = 0; i < 8; i++) begin
                if (apply_mask && (i < epl) && !done_bus.vm[l*epl + i]) begin
                    elem_w[l] = elem_put(elem_w[l], done_bus.sew, 3'(i),
                                         elem_get(old_w[l], done_bus.sew, 3'(i)));
                end
            end
        end
        if (is_red) begin
            elem_w    = old_w;
            elem_w[0] = elem_put(old_w[0], done_bus.sew, 3'd0, red_i);
        end
    end

    // Packed compare mask, tail bits read as one
    always_comb begin
        mask_res = '1;
        for (int l = 0; l < LANES; l++) begin
            for (int i = 0; i < 8; i++) begin
                if (i < epl) begin
                    if (!apply_mask || done_bus.vm[l*epl + i]) begin
                        mask_res[l*epl + i] = cmp_i[l][i];
                    end else begin
                        mask_res[l*epl + i] = done_bus.old_vd[l*epl + i];
                    end
                end
            end
        end
    end

    assign vec_valid_o     = done_bus.valid && !is_mv;
    assign vec_tag_o       = done_bus.tag;
    assign vec_result_o    = is_cmp ? mask_res : elem_w;
    assign scalar_valid_o  = done_bus.valid && is_mv;
    assign scalar_tag_o    = done_bus.tag;
    assign scalar_result_o = elem_get(vs2_l0, done_bus.sew, 3'd0);  // Sign-extended element 0

endmodule

//--- src/simd_unit.sv
// Vector execution stage joining operand mux, lanes, reduction, latency pipe and merge
`timescale 1ns/1ns

module simd_unit #(
    parameter int VLEN = 128
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       valid_i,
    input  simd_pkg::simd_op_e         op_i,
    input  simd_pkg::sew_e             sew_i,
    input  logic                       scalar_src_i,
    input  logic                       use_mask_i,
    input  logic [VLEN-1:0]            vs1_i,
    input  logic [VLEN-1:0]            vs2_i,
    input  logic [VLEN-1:0]            old_vd_i,
    input  logic [VLEN-1:0]            vm_i,
    input  logic [simd_pkg::ELEN-1:0]  rs1_i,
    input  logic [simd_pkg::TAG_W-1:0] tag_i,
    output logic                       vec_valid_o,
    output logic [simd_pkg::TAG_W-1:0] vec_tag_o,
    output logic [VLEN-1:0]            vec_result_o,
    output logic                       scalar_valid_o,
    output logic [simd_pkg::TAG_W-1:0] scalar_tag_o,
    output logic [simd_pkg::ELEN-1:0]  scalar_result_o
);
    localparam int LANES = VLEN / simd_pkg::ELEN;

    simd_instr_if #(.VLEN(VLEN)) issue_bus ();
    simd_instr_if #(.VLEN(VLEN)) done_bus ();

    logic [VLEN-1:0]                  vs1_sel;
    simd_pkg::lane_word_u [LANES-1:0] alu_w;
    simd_pkg::lane_word_u [LANES-1:0] mul_w;
    logic [LANES-1:0][7:0]            cmp_w;
    logic [63:0]                      red_w;

    assign issue_bus.valid      = valid_i;
    assign issue_bus.op         = op_i;
    assign issue_bus.sew        = sew_i;
    assign issue_bus.scalar_src = scalar_src_i;
    assign issue_bus.use_mask   = use_mask_i;
    assign issue_bus.vs1        = vs1_i;
    assign issue_bus.vs2        = vs2_i;
    assign issue_bus.old_vd     = old_vd_i;
    assign issue_bus.vm         = vm_i;
    assign issue_bus.rs1        = rs1_i;
    assign issue_bus.tag        = tag_i;

    simd_operand_mux #(.VLEN(VLEN)) simd_operand_mux_i (
        .issue_bus (issue_bus),
        .vs1_sel_o (vs1_sel)
    );

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        simd_lane simd_lane_i (
            .clk_i  (clk_i),
            .rstn_i (rstn_i),
            .op_i   (op_i),
            .sew_i  (sew_i),
            .a_i    (vs1_sel[l*simd_pkg::ELEN +: simd_pkg::ELEN]),
            .b_i    (vs2_i[l*simd_pkg::ELEN +: simd_pkg::ELEN]),
            .alu_o  (alu_w[l]),
            .cmp_o  (cmp_w[l]),
            .mul_o  (mul_w[l])
        );
    end

    simd_latency_pipe #(.VLEN(VLEN)) simd_latency_pipe_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .issue_bus (issue_bus),
        .done_bus  (done_bus)
    );

    simd_reduction #(.VLEN(VLEN)) simd_reduction_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .op_i   (op_i),
        .sew_i  (sew_i),
        .vs1_i  (vs1_sel),
        .vs2_i  (vs2_i),
        .red_o  (red_w)
    );

    simd_result_merge #(.VLEN(VLEN)) simd_result_merge_i (
        .done_bus        (done_bus),
        .alu_i           (alu_w),
        .mul_i           (mul_w),
        .cmp_i           (cmp_w),
        .red_i           (red_w),
        .vec_valid_o     (vec_valid_o),
        .vec_tag_o       (vec_tag_o),
        .vec_result_o    (vec_result_o),
        .scalar_valid_o  (scalar_valid_o),
        .scalar_tag_o    (scalar_tag_o),
        .scalar_result_o (scalar_result_o)
    );

endmodule

//--- tests/tb_clock.sv
// Testbench clock and reset generator for the vector execution stage
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release lines up with the stimulus drive point after a rising edge
    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2 rstn_o = 1'b1;
    end

endmodule

//--- tests/simd_ref_model.svh
// Reference model computing the expected vector or scalar result of one instruction
`ifndef SIMD_REF_MODEL_SVH
`define SIMD_REF_MODEL_SVH

function automatic int element_bits(sew_e cur_sew);
    case (cur_sew)
        SEW_8:   return 8;
        SEW_16:  return 16;
        SEW_32:  return 32;
        default: return 64;
    endcase
endfunction

function automatic int expected_latency(simd_op_e cur_op);
    case (cur_op)
        VMUL:                              return 2;
        VREDSUM, VREDAND, VREDOR, VREDXOR: return 3;
        default:                           return 1;
    endcase
endfunction

function automatic logic [63:0] width_mask(int bits);
    return (bits == 64) ? '1 : ((64'd1 << bits) - 64'd1);
endfunction

function automatic logic [63:0] read_element(logic [VLEN-1:0] vec, int bits, int idx);
    logic [VLEN-1:0] shifted;
    shifted = vec >> (idx * bits);
    return shifted[63:0] & width_mask(bits);
endfunction

function automatic logic [VLEN-1:0] write_element(logic [VLEN-1:0] vec, int bits, int idx,
                                                  logic [63:0] val);
    logic [VLEN-1:0] field;
    field = VLEN'(width_mask(bits)) << (idx * bits);
    return (vec & ~field) | (VLEN'(val & width_mask(bits)) << (idx * bits));
endfunction

function automatic logic [63:0] sign_extend(logic [63:0] val, int bits);
    if ((bits < 64) && val[bits-1]) begin
        return val | ~width_mask(bits);
    end
    return val;
endfunction

function automatic logic [VLEN-1:0] expected_result(
    simd_op_e cur_op, sew_e cur_sew, logic cur_scalar, logic cur_mask,
    logic [VLEN-1:0] a_vec, logic [VLEN-1:0] b_vec, logic [VLEN-1:0] old_vec,
    logic [VLEN-1:0] mask_vec, logic [63:0] scalar_val
);
    int              bits;
    int              n;
    logic [63:0]     a;
    logic [63:0]     b;
    logic [63:0]     r;
    logic            bit_r;
    logic [VLEN-1:0] res;
    bits = element_bits(cur_sew);
    n    = VLEN / bits;
    res  = old_vec;
    case (cur_op)
        VMV_X_S: res = VLEN'(sign_extend(read_element(b_vec, bits, 0), bits));
        VREDSUM, VREDAND, VREDOR, VREDXOR: begin  // Seed from element 0 of source one
            r = cur_scalar ? (scalar_val & width_mask(bits)) : read_element(a_vec, bits, 0);
            for (int e = 0; e < n; e++) begin
                b = read_element(b_vec, bits, e);
                case (cur_op)
                    VREDAND: r = r & b;
                    VREDOR:  r = r | b;
                    VREDXOR: r = r ^ b;
                    default: r = r + b;
                endcase
            end
            res = write_element(old_vec, bits, 0, r);  // Mask ignored
        end
        VMSEQ, VMSLT, VMSLTU: begin
            res = '1;  // Tail bits read as one
            for (int e = 0; e < n; e++) begin
                a = cur_scalar ? (scalar_val & width_mask(bits)) : read_element(a_vec, bits, e);
                b = read_element(b_vec, bits, e);
                case (cur_op)
                    VMSEQ:   bit_r = (b == a);
                    VMSLT:   bit_r = $signed(sign_extend(b, bits)) < $signed(sign_extend(a, bits));
                    default: bit_r = (b < a);
                endcase
                res[e] = (cur_mask && !mask_vec[e]) ? old_vec[e] : bit_r;
            end
        end
        default: begin
            for (int e = 0; e < n; e++) begin
                a = cur_scalar ? (scalar_val & width_mask(bits)) : read_element(a_vec, bits, e);
                b = read_element(b_vec, bits, e);
                case (cur_op)
                    VADD:    r = b + a;
                    VSUB:    r = b - a;
                    VAND:    r = b & a;
                    VOR:     r = b | a;
                    VXOR:    r = b ^ a;
                    VMUL:    r = b * a;  // Low half only
                    default: r = '0;
                endcase
                if (!cur_mask || mask_vec[e]) begin
                    res = write_element(res, bits, e, r);
                end
            end
        end
    endcase
    return res;
endfunction

`endif

//--- tests/tb_simd_unit.sv
// Testbench for the vector execution stage with directed sweeps, random mix and a scoreboard
`timescale 1ns/1ns

module tb_simd_unit;
    import simd_pkg::*;

    localparam int VLEN      = 128;
    localparam int PERIOD_NS = 40;
    localparam int RESET_CYC = 16;
    localparam int SEED      = 96318;
    localparam int NUM_OPS   = 14;
    localparam int NUM_SWEEP = NUM_OPS * 4 * 4;  // Every op, SEW, scalar and mask choice
    localparam int NUM_RAND  = 200;
    localparam int NUM_INSTR = NUM_SWEEP + NUM_RAND;
    localparam int MARGIN    = 50;

    `include "simd_ref_model.svh"

    typedef struct {
        int               due;
        logic             is_scalar;
        logic [TAG_W-1:0] tag;
        logic [VLEN-1:0]  value;
    } expect_t;

    logic             clk;
    logic             rstn;
    logic             valid;
    simd_op_e         op;
    sew_e             sew;
    logic             scalar_src;
    logic             use_mask;
    logic [VLEN-1:0]  vs1;
    logic [VLEN-1:0]  vs2;
    logic [VLEN-1:0]  old_vd;
    logic [VLEN-1:0]  vm;
    logic [63:0]      rs1;
    logic [TAG_W-1:0] tag;
    logic             vec_valid;
    logic [TAG_W-1:0] vec_tag;
    logic [VLEN-1:0]  vec_result;
    logic             scalar_valid;
    logic [TAG_W-1:0] scalar_tag;
    logic [63:0]      scalar_result;

    expect_t exp_q[$];
    int      cyc       = 0;
    int      err_cnt   = 0;
    int      proto_cnt = 0;
    int      issued    = 0;

    tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYC)) tb_clock_i (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    simd_unit #(.VLEN(VLEN)) simd_unit_i (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .valid_i         (valid),
        .op_i            (op),
        .sew_i           (sew),
        .scalar_src_i    (scalar_src),
        .use_mask_i      (use_mask),
        .vs1_i           (vs1),
        .vs2_i           (vs2),
        .old_vd_i        (old_vd),
        .vm_i            (vm),
        .rs1_i           (rs1),
        .tag_i           (tag),
        .vec_valid_o     (vec_valid),
        .vec_tag_o       (vec_tag),
        .vec_result_o    (vec_result),
        .scalar_valid_o  (scalar_valid),
        .scalar_tag_o    (scalar_tag),
        .scalar_result_o (scalar_result)
    );

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_value(string name, logic [VLEN-1:0] got, logic [VLEN-1:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got %h, expected %h in cycle %0d", name, got, exp, cyc);
        end
    endtask

    function automatic logic [VLEN-1:0] random_vector();
        logic [VLEN-1:0] v;
        for (int i = 0; i < VLEN / 32; i++) begin
            v[i*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    function automatic bit completion_due(int due);
        foreach (exp_q[i]) begin
            if (exp_q[i].due == due) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Called just after a rising edge and returns at the same point of a later cycle
    task automatic issue_instr(simd_op_e cmd_op, sew_e cmd_sew, logic cmd_scalar, logic cmd_mask);
        expect_t         item;
        logic [VLEN-1:0] v1;
        logic [VLEN-1:0] v2;
        logic [VLEN-1:0] noise;
        logic [63:0]     r1;
        int              lat;
        v1    = random_vector();
        v2    = random_vector();
        noise = random_vector() & random_vector() & random_vector();
        r1    = {$urandom, $urandom};
        if (cmd_op == VMSEQ) begin  // Few differing bits so equal elements show up
            v1 = v2 ^ noise;
            if (cmd_scalar) begin
                v2 = {(VLEN / 64){r1}} ^ noise;
            end
        end
        lat = expected_latency(cmd_op);
        while (completion_due(cyc + lat)) begin  // Would complete with an earlier one
            valid = 1'b0;
            @(posedge clk);
            #2;
        end
        valid      = 1'b1;
        op         = cmd_op;
        sew        = cmd_sew;
        scalar_src = cmd_scalar;
        use_mask   = cmd_mask;
        vs1        = v1;
        vs2        = v2;
        old_vd     = random_vector();
        vm         = random_vector();
        rs1        = r1;
        tag        = TAG_W'(issued);
        item.due       = cyc + lat;
        item.is_scalar = (cmd_op == VMV_X_S);
        item.tag       = tag;
        item.value     = expected_result(cmd_op, cmd_sew, cmd_scalar, cmd_mask,
                                         v1, v2, old_vd, vm, r1);
        exp_q.push_back(item);
        issued++;
        @(posedge clk);
        #2;
        valid = 1'b0;
    endtask

    // Outputs are sampled mid-cycle where they are settled
    always @(negedge clk) begin : compare_outputs
        int idx;
        idx = -1;
        foreach (exp_q[i]) begin
            if (exp_q[i].due == cyc) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            if ((vec_valid !== 1'b0) || (scalar_valid !== 1'b0)) begin
                proto_cnt++;
                $display("Valid output raised in cycle %0d with no result due", cyc);
            end
        end else if (exp_q[idx].is_scalar) begin
            if (scalar_valid !== 1'b1) begin
                proto_cnt++;
                $display("Scalar result with tag %h missing in cycle %0d", exp_q[idx].tag, cyc);
            end else begin
                check_value("scalar_tag_o", scalar_tag, exp_q[idx].tag);
                check_value("scalar_result_o", scalar_result, exp_q[idx].value);
            end
            check_value("vec_valid_o", vec_valid, 1'b0);
            exp_q.delete(idx);
        end else begin
            if (vec_valid !== 1'b1) begin
                proto_cnt++;
                $display("Vector result with tag %h missing in cycle %0d", exp_q[idx].tag, cyc);
            end else begin
                check_value("vec_tag_o", vec_tag, exp_q[idx].tag);
                check_value("vec_result_o", vec_result, exp_q[idx].value);
            end
            check_value("scalar_valid_o", scalar_valid, 1'b0);
            exp_q.delete(idx);
        end
    end

    initial begin : stimulus
        simd_op_e rnd_op;
        sew_e     rnd_sew;
        void'($urandom(SEED));
        valid      = 1'b0;
        op         = VNOP;
        sew        = SEW_8;
        scalar_src = 1'b0;
        use_mask   = 1'b0;
        vs1        = '0;
        vs2        = '0;
        old_vd     = '0;
        vm         = '0;
        rs1        = '0;
        tag        = '0;
        @(posedge rstn);
        @(posedge clk);
        #2;
        for (int o = 1; o <= NUM_OPS; o++) begin  // Same op back to back at every SEW
            for (int s = 0; s < 4; s++) begin
                for (int m = 0; m < 4; m++) begin
                    issue_instr(simd_op_e'(o), sew_e'(s), m[0], m[1]);
                end
            end
        end
        for (int k = 0; k < NUM_RAND; k++) begin
            rnd_op  = simd_op_e'(1 + ($urandom % NUM_OPS));
            rnd_sew = sew_e'($urandom % 4);
            issue_instr(rnd_op, rnd_sew, 1'($urandom % 2), 1'($urandom % 2));
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("Run complete: %0d instructions, %0d mismatches, %0d protocol errors",
                 issued, err_cnt, proto_cnt);
        if ((err_cnt == 0) && (proto_cnt == 0)) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Each instruction needs at most MAX_LAT issue cycles including skipped ones
    initial begin : watchdog
        #((RESET_CYC + NUM_INSTR * MAX_LAT + MARGIN) * PERIOD_NS);
        $display("Watchdog expired in cycle %0d with %0d results still pending", cyc, exp_q.size());
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tests
src/simd_pkg.sv
src/simd_instr_if.sv
src/simd_operand_mux.sv
src/simd_lane.sv
src/simd_latency_pipe.sv
src/simd_reduction.sv
src/simd_result_merge.sv
src/simd_unit.sv
tests/tb_clock.sv
tests/tb_simd_unit.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_simd_unit
FILELIST := verilog.f
OBJ_DIR  := obj_dir
LOG      := sim.log

SHELL := /bin/bash

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard tests/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	set -o pipefail; ./$(BIN) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
